/* rtl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  typedef logic [31:0] word_t;
  typedef logic [13:0] csr_addr_t;
  typedef logic [5:0]  ecode_t;
  typedef logic [8:0]  esubcode_t;

  localparam int MAX_SAVE = 8;

  localparam csr_addr_t CSR_CRMD      = 14'h0;
  localparam csr_addr_t CSR_PRMD      = 14'h1;
  localparam csr_addr_t CSR_ESTAT     = 14'h5;
  localparam csr_addr_t CSR_ERA       = 14'h6;
  localparam csr_addr_t CSR_BADV      = 14'h7;
  localparam csr_addr_t CSR_EENTRY    = 14'hc;
  localparam csr_addr_t CSR_SAVE_BASE = 14'h30;
  localparam csr_addr_t CSR_TID       = 14'h40;
  localparam csr_addr_t CSR_TCFG      = 14'h41;
  localparam csr_addr_t CSR_TVAL      = 14'h42;
  localparam csr_addr_t CSR_TICLR     = 14'h44;

  // lsb of each field
  localparam int CRMD_PLV       = 0;
  localparam int CRMD_IE        = 2;
  localparam int CRMD_DA        = 3;
  localparam int CRMD_PG        = 4;
  localparam int CRMD_DATF      = 5;
  localparam int CRMD_DATM      = 7;
  localparam int PRMD_PPLV      = 0;
  localparam int PRMD_PIE       = 2;
  localparam int ESTAT_IS_SW    = 0;
  localparam int ESTAT_IS_HW    = 2;
  localparam int ESTAT_TI       = 11;
  localparam int ESTAT_ECODE    = 16;
  localparam int ESTAT_ESUBCODE = 22;
  localparam int TCFG_EN        = 0;
  localparam int TCFG_PERIODIC  = 1;
  localparam int TCFG_INITVAL   = 2;
  localparam int TICLR_CLR      = 0;
  localparam int EENTRY_VA      = 6;

  localparam ecode_t ECODE_INT = 6'h0;
  localparam ecode_t ECODE_ADE = 6'h8;
  localparam ecode_t ECODE_ALE = 6'h9;
  localparam ecode_t ECODE_SYS = 6'hb;
  localparam ecode_t ECODE_BRK = 6'hc;
  localparam ecode_t ECODE_INE = 6'hd;
  localparam ecode_t ECODE_IPE = 6'he;

  localparam esubcode_t ESUBCODE_ADEF = 9'd0;
  localparam esubcode_t ESUBCODE_ADEM = 9'd1;

  typedef struct packed {
    logic intr;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_flags_t;

  typedef enum logic [1:0] {
    RDCNT_CSR   = 2'd0,
    RDCNT_ID    = 2'd1,
    RDCNT_VLOW  = 2'd2,
    RDCNT_VHIGH = 2'd3
  } rdcnt_e;

  typedef struct packed {
    logic crmd;
    logic prmd;
    logic estat;
    logic era;
    logic badv;
    logic eentry;
    logic tid;
    logic tcfg;
    logic ticlr;
    logic [MAX_SAVE-1:0] save;
    word_t data;
  } csr_wr_t;

  typedef struct packed {
    word_t crmd;
    word_t prmd;
    word_t estat;
    word_t era;
    word_t badv;
  } csr_view_t;

endpackage

`default_nettype wire

/* rtl/csr_write_port.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_write_port #(
  parameter int NUM_SAVE = 4
) (
  input  logic                stall_i,
  input  logic                we_i,
  input  csr_pkg::csr_addr_t  w_addr_i,
  input  csr_pkg::word_t      w_mask_i,
  input  csr_pkg::word_t      w_data_i,
  input  csr_pkg::word_t      old_value_i,
  output csr_pkg::csr_wr_t    wr_o
);

  import csr_pkg::*;

  logic wr_en;

  assign wr_en = we_i && !stall_i;

  always_comb begin
    wr_o        = '0;
    wr_o.crmd   = wr_en && (w_addr_i == CSR_CRMD);
    wr_o.prmd   = wr_en && (w_addr_i == CSR_PRMD);
    wr_o.estat  = wr_en && (w_addr_i == CSR_ESTAT);
    wr_o.era    = wr_en && (w_addr_i == CSR_ERA);
    wr_o.badv   = wr_en && (w_addr_i == CSR_BADV);
    wr_o.eentry = wr_en && (w_addr_i == CSR_EENTRY);
    wr_o.tid    = wr_en && (w_addr_i == CSR_TID);
    wr_o.tcfg   = wr_en && (w_addr_i == CSR_TCFG);
    wr_o.ticlr  = wr_en && (w_addr_i == CSR_TICLR);
    // save slots sit at consecutive addresses
    for (int n = 0; n < NUM_SAVE; n++) begin
      wr_o.save[n] = wr_en && (w_addr_i == CSR_SAVE_BASE + csr_addr_t'(n));
    end
    // keep old bits outside the mask
    wr_o.data = (old_value_i & ~w_mask_i) | (w_data_i & w_mask_i);

    assert ($onehot0({wr_o.crmd, wr_o.prmd, wr_o.estat, wr_o.era, wr_o.badv,
                      wr_o.eentry, wr_o.tid, wr_o.tcfg, wr_o.ticlr, wr_o.save}))
      else $error("csr_write_port: more than one write strobe active");
  end

endmodule

`default_nettype wire

/* rtl/csr_exception_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_exception_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_wr_t      wr_i,
  input  csr_pkg::excp_flags_t  excp_i,
  input  logic                  ertn_i,
  input  logic [7:0]            int_i,
  input  csr_pkg::word_t        pc_i,
  input  csr_pkg::word_t        vaddr_i,
  input  logic                  timer_pending_i,
  output csr_pkg::csr_view_t    view_o,
  output logic                  irq_pending_o
);

  import csr_pkg::*;

  logic      excp_valid;
  ecode_t    ecode;
  esubcode_t esubcode;

  word_t     crmd_q;
  word_t     prmd_q;
  logic [1:0] swi_q;
  logic [7:0] hwi_q;
  ecode_t    ecode_q;
  esubcode_t esubcode_q;
  word_t     era_q;
  word_t     badv_q;

  assign excp_valid = |excp_i;

  // first set flag wins
  always_comb begin
    ecode    = ECODE_INT;
    esubcode = '0;
    case (1'b1)
      excp_i.intr: ecode = ECODE_INT;
      excp_i.adef: begin
        ecode    = ECODE_ADE;
        esubcode = ESUBCODE_ADEF;
      end
      excp_i.adem: begin
        ecode    = ECODE_ADE;
        esubcode = ESUBCODE_ADEM;
      end
      excp_i.ale: ecode = ECODE_ALE;
      excp_i.sys: ecode = ECODE_SYS;
      excp_i.brk: ecode = ECODE_BRK;
      excp_i.ine: ecode = ECODE_INE;
      excp_i.ipe: ecode = ECODE_IPE;
      default: ;
    endcase
  end

  // crmd and prmd, software write last so it wins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q          <= '0;
      crmd_q[CRMD_DA] <= 1'b1;
      prmd_q          <= '0;
    end else begin
      if (excp_valid) begin
        prmd_q[PRMD_PPLV +: 2] <= crmd_q[CRMD_PLV +: 2];
        prmd_q[PRMD_PIE]       <= crmd_q[CRMD_IE];
        crmd_q[CRMD_PLV +: 2]  <= 2'b0;
        crmd_q[CRMD_IE]        <= 1'b0;
      end else if (ertn_i) begin
        crmd_q[CRMD_PLV +: 2] <= prmd_q[PRMD_PPLV +: 2];
        crmd_q[CRMD_IE]       <= prmd_q[PRMD_PIE];
      end
      if (wr_i.crmd) begin
        crmd_q[CRMD_PLV +: 2]  <= wr_i.data[CRMD_PLV +: 2];
        crmd_q[CRMD_IE]        <= wr_i.data[CRMD_IE];
        crmd_q[CRMD_DA]        <= wr_i.data[CRMD_DA];
        crmd_q[CRMD_PG]        <= wr_i.data[CRMD_PG];
        crmd_q[CRMD_DATF +: 2] <= wr_i.data[CRMD_DATF +: 2];
        crmd_q[CRMD_DATM +: 2] <= wr_i.data[CRMD_DATM +: 2];
      end
      if (wr_i.prmd) begin
        prmd_q[PRMD_PPLV +: 2] <= wr_i.data[PRMD_PPLV +: 2];
        prmd_q[PRMD_PIE]       <= wr_i.data[PRMD_PIE];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      swi_q      <= '0;
      hwi_q      <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
    end else begin
      hwi_q <= int_i;
      if (excp_valid) begin
        ecode_q    <= ecode;
        esubcode_q <= esubcode;
      end
      if (wr_i.estat) begin
        swi_q <= wr_i.data[ESTAT_IS_SW +: 2];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q  <= '0;
      badv_q <= '0;
    end else begin
      if (excp_valid) begin
        era_q <= pc_i;
      end
      if (excp_i.adef) begin
        badv_q <= pc_i;
      end else if (excp_i.adem || excp_i.ale) begin
        badv_q <= vaddr_i;
      end
      if (wr_i.era) begin
        era_q <= wr_i.data;
      end
      if (wr_i.badv) begin
        badv_q <= wr_i.data;
      end
    end
  end

  // TI comes straight from the timer
  always_comb begin
    view_o.crmd                          = crmd_q;
    view_o.prmd                          = prmd_q;
    view_o.era                           = era_q;
    view_o.badv                          = badv_q;
    view_o.estat                         = '0;
    view_o.estat[ESTAT_IS_SW +: 2]       = swi_q;
    view_o.estat[ESTAT_IS_HW +: 8]       = hwi_q;
    view_o.estat[ESTAT_TI]               = timer_pending_i;
    view_o.estat[ESTAT_ECODE +: 6]       = ecode_q;
    view_o.estat[ESTAT_ESUBCODE +: 9]    = esubcode_q;
  end

  assign irq_pending_o = crmd_q[CRMD_IE] && ((|swi_q) || (|hwi_q) || timer_pending_i);

  excp_ertn_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(excp_valid && ertn_i))
    else $error("csr_exception_unit: exception and ertn in the same cycle");

endmodule

`default_nettype wire

/* rtl/csr_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_timer (
  input  logic              clk,
  input  logic              rst_n,
  input  csr_pkg::csr_wr_t  wr_i,
  output csr_pkg::word_t    tcfg_o,
  output csr_pkg::word_t    tval_o,
  output logic [63:0]       counter_o,
  output logic              timer_pending_o
);

  import csr_pkg::*;

  word_t       tcfg_q;
  word_t       tval_q;
  logic        timer_en_q;
  logic        pending_q;
  logic [63:0] counter_q;
  word_t       reload;
  logic        clear;

  // initval counts in units of four cycles
  assign reload = {tcfg_q[31:TCFG_INITVAL], 2'b00};
  assign clear  = wr_i.ticlr && wr_i.data[TICLR_CLR];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
      pending_q  <= 1'b0;
    end else begin
      if (wr_i.tcfg) begin
        tcfg_q     <= wr_i.data;
        tval_q     <= {wr_i.data[31:TCFG_INITVAL], 2'b00};
        timer_en_q <= wr_i.data[TCFG_EN];
      end else if (timer_en_q) begin
        if (tval_q == '0) begin
          pending_q  <= 1'b1;
          timer_en_q <= tcfg_q[TCFG_PERIODIC];
          tval_q     <= tcfg_q[TCFG_PERIODIC] ? reload : '1;
        end else begin
          tval_q <= tval_q - word_t'(1);
        end
      end
      // clear beats both a new config and an expiry
      if (clear) begin
        pending_q <= 1'b0;
      end
    end
  end

  // stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      counter_q <= '0;
    end else begin
      counter_q <= counter_q + 64'd1;
    end
  end

  assign tcfg_o          = tcfg_q;
  assign tval_o          = tval_q;
  assign counter_o       = counter_q;
  assign timer_pending_o = pending_q;

  // while running, tval never exceeds the reload value
  tval_within_reload: assert property (@(posedge clk) disable iff (!rst_n)
    timer_en_q |-> (tval_q <= reload))
    else $error("csr_timer: running countdown above the configured reload value");

endmodule

`default_nettype wire

/* rtl/csr_scratch_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_scratch_regs #(
  parameter int NUM_SAVE = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  csr_pkg::csr_wr_t                    wr_i,
  output csr_pkg::word_t [NUM_SAVE-1:0]       save_o,
  output csr_pkg::word_t                      eentry_o,
  output csr_pkg::word_t                      tid_o
);

  import csr_pkg::*;

  word_t [NUM_SAVE-1:0] save_q;
  word_t                eentry_q;
  word_t                tid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      save_q   <= '0;
      eentry_q <= '0;
      tid_q    <= '0;
    end else begin
      for (int n = 0; n < NUM_SAVE; n++) begin
        if (wr_i.save[n]) begin
          save_q[n] <= wr_i.data;
        end
      end
      // entry is 64-byte aligned
      if (wr_i.eentry) begin
        eentry_q[31:EENTRY_VA] <= wr_i.data[31:EENTRY_VA];
      end
      if (wr_i.tid) begin
        tid_q <= wr_i.data;
      end
    end
  end

  assign save_o   = save_q;
  assign eentry_o = eentry_q;
  assign tid_o    = tid_q;

endmodule

`default_nettype wire

/* rtl/csr_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux #(
  parameter int NUM_SAVE = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           stall_i,
  input  csr_pkg::csr_addr_t             r_addr_i,
  input  csr_pkg::rdcnt_e                rdcnt_i,
  input  csr_pkg::csr_addr_t             w_addr_i,
  input  csr_pkg::csr_view_t             view_i,
  input  csr_pkg::word_t                 tcfg_i,
  input  csr_pkg::word_t                 tval_i,
  input  logic [63:0]                    counter_i,
  input  csr_pkg::word_t [NUM_SAVE-1:0]  save_i,
  input  csr_pkg::word_t                 eentry_i,
  input  csr_pkg::word_t                 tid_i,
  output csr_pkg::word_t                 r_data_o,
  output csr_pkg::word_t                 old_value_o
);

  import csr_pkg::*;

  word_t r_data_q;

  // unmapped addresses and ticlr read as zero
  function automatic word_t lookup(input csr_addr_t addr);
    word_t value;
    value = '0;
    case (addr)
      CSR_CRMD:   value = view_i.crmd;
      CSR_PRMD:   value = view_i.prmd;
      CSR_ESTAT:  value = view_i.estat;
      CSR_ERA:    value = view_i.era;
      CSR_BADV:   value = view_i.badv;
      CSR_EENTRY: value = eentry_i;
      CSR_TID:    value = tid_i;
      CSR_TCFG:   value = tcfg_i;
      CSR_TVAL:   value = tval_i;
      default: begin
        for (int n = 0; n < NUM_SAVE; n++) begin
          if (addr == CSR_SAVE_BASE + csr_addr_t'(n)) begin
            value = save_i[n];
          end
        end
      end
    endcase
    return value;
  endfunction

  // holds while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data_q <= '0;
    end else if (!stall_i) begin
      case (rdcnt_i)
        RDCNT_ID:    r_data_q <= tid_i;
        RDCNT_VLOW:  r_data_q <= counter_i[31:0];
        RDCNT_VHIGH: r_data_q <= counter_i[63:32];
        default:     r_data_q <= lookup(r_addr_i);
      endcase
    end
  end

  always_comb begin
    old_value_o = lookup(w_addr_i);
  end

  assign r_data_o = r_data_q;

endmodule

`default_nettype wire

/* rtl/csr_file.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_file #(
  parameter int NUM_SAVE = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall_i,
  input  csr_pkg::csr_addr_t    csr_r_addr_i,
  input  csr_pkg::rdcnt_e       rdcnt_i,
  input  logic                  csr_we_i,
  input  csr_pkg::csr_addr_t    csr_w_addr_i,
  input  csr_pkg::word_t        csr_w_mask_i,
  input  csr_pkg::word_t        csr_w_data_i,
  input  csr_pkg::excp_flags_t  excp_i,
  input  logic                  ertn_i,
  input  logic [7:0]            int_i,
  input  csr_pkg::word_t        pc_i,
  input  csr_pkg::word_t        vaddr_i,
  output csr_pkg::word_t        csr_r_data_o,
  output csr_pkg::word_t        crmd_o,
  output csr_pkg::word_t        eentry_o,
  output logic                  irq_pending_o
);

  import csr_pkg::*;

  csr_wr_t              wr;
  word_t                old_value;
  csr_view_t            view;
  logic                 timer_pending;
  word_t                tcfg;
  word_t                tval;
  logic [63:0]          counter;
  word_t [NUM_SAVE-1:0] save;
  word_t                eentry;
  word_t                tid;

  csr_write_port #(
    .NUM_SAVE (NUM_SAVE)
  ) csr_write_port_i (
    .stall_i     (stall_i),
    .we_i        (csr_we_i),
    .w_addr_i    (csr_w_addr_i),
    .w_mask_i    (csr_w_mask_i),
    .w_data_i    (csr_w_data_i),
    .old_value_i (old_value),
    .wr_o        (wr)
  );

  csr_exception_unit csr_exception_unit_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_i            (wr),
    .excp_i          (excp_i),
    .ertn_i          (ertn_i),
    .int_i           (int_i),
    .pc_i            (pc_i),
    .vaddr_i         (vaddr_i),
    .timer_pending_i (timer_pending),
    .view_o          (view),
    .irq_pending_o   (irq_pending_o)
  );

  csr_timer csr_timer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_i            (wr),
    .tcfg_o          (tcfg),
    .tval_o          (tval),
    .counter_o       (counter),
    .timer_pending_o (timer_pending)
  );

  csr_scratch_regs #(
    .NUM_SAVE (NUM_SAVE)
  ) csr_scratch_regs_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_i     (wr),
    .save_o   (save),
    .eentry_o (eentry),
    .tid_o    (tid)
  );

  csr_read_mux #(
    .NUM_SAVE (NUM_SAVE)
  ) csr_read_mux_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall_i     (stall_i),
    .r_addr_i    (csr_r_addr_i),
    .rdcnt_i     (rdcnt_i),
    .w_addr_i    (csr_w_addr_i),
    .view_i      (view),
    .tcfg_i      (tcfg),
    .tval_i      (tval),
    .counter_i   (counter),
    .save_i      (save),
    .eentry_i    (eentry),
    .tid_i       (tid),
    .r_data_o    (csr_r_data_o),
    .old_value_o (old_value)
  );

  assign crmd_o   = view.crmd;
  assign eentry_o = eentry;

endmodule

`default_nettype wire

/* verif/csr_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_tb;

  import csr_pkg::*;

  localparam int NUM_SAVE = 4;
  localparam int TIMEOUT  = 200;

  logic        clk;
  logic        rst_n;
  logic        stall_i;
  csr_addr_t   csr_r_addr_i;
  rdcnt_e      rdcnt_i;
  logic        csr_we_i;
  csr_addr_t   csr_w_addr_i;
  word_t       csr_w_mask_i;
  word_t       csr_w_data_i;
  excp_flags_t excp_i;
  logic        ertn_i;
  logic [7:0]  int_i;
  word_t       pc_i;
  word_t       vaddr_i;
  word_t       csr_r_data_o;
  word_t       crmd_o;
  word_t       eentry_o;
  logic        irq_pending_o;

  integer seed;

  // reference model state
  word_t       exp_crmd;
  word_t       exp_prmd;
  word_t       exp_era;
  word_t       exp_badv;
  word_t       exp_eentry;
  word_t       exp_tid;
  word_t       exp_tcfg;
  word_t       exp_tval;
  word_t       exp_rdata;
  word_t       exp_save [NUM_SAVE];
  logic [1:0]  exp_swi;
  logic [7:0]  exp_hwi;
  ecode_t      exp_ecode;
  esubcode_t   exp_esub;
  logic        exp_ten;
  logic        exp_pending;
  logic [63:0] exp_counter;

  csr_file #(
    .NUM_SAVE (NUM_SAVE)
  ) csr_file_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall_i       (stall_i),
    .csr_r_addr_i  (csr_r_addr_i),
    .rdcnt_i       (rdcnt_i),
    .csr_we_i      (csr_we_i),
    .csr_w_addr_i  (csr_w_addr_i),
    .csr_w_mask_i  (csr_w_mask_i),
    .csr_w_data_i  (csr_w_data_i),
    .excp_i        (excp_i),
    .ertn_i        (ertn_i),
    .int_i         (int_i),
    .pc_i          (pc_i),
    .vaddr_i       (vaddr_i),
    .csr_r_data_o  (csr_r_data_o),
    .crmd_o        (crmd_o),
    .eentry_o      (eentry_o),
    .irq_pending_o (irq_pending_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("ERR %0t %s actual=0x%08h expected=0x%08h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  function automatic word_t rand_word();
    return $random(seed);
  endfunction

  // 16 read/write targets, the last two unmapped
  function automatic csr_addr_t pick_addr(input logic [3:0] idx);
    case (idx)
      4'd0:    return CSR_CRMD;
      4'd1:    return CSR_PRMD;
      4'd2:    return CSR_ESTAT;
      4'd3:    return CSR_ERA;
      4'd4:    return CSR_BADV;
      4'd5:    return CSR_EENTRY;
      4'd6:    return 14'h30;
      4'd7:    return 14'h31;
      4'd8:    return 14'h32;
      4'd9:    return 14'h33;
      4'd10:   return CSR_TID;
      4'd11:   return CSR_TCFG;
      4'd12:   return CSR_TVAL;
      4'd13:   return CSR_TICLR;
      4'd14:   return 14'h2;
      default: return 14'h34;
    endcase
  endfunction

  function automatic word_t model_read(input csr_addr_t addr);
    word_t v;
    v = 32'h0;
    case (addr)
      CSR_CRMD:   v = exp_crmd;
      CSR_PRMD:   v = exp_prmd;
      CSR_ESTAT:  v = {1'b0, exp_esub, exp_ecode, 4'b0, exp_pending, 1'b0, exp_hwi, exp_swi};
      CSR_ERA:    v = exp_era;
      CSR_BADV:   v = exp_badv;
      CSR_EENTRY: v = exp_eentry;
      CSR_TID:    v = exp_tid;
      CSR_TCFG:   v = exp_tcfg;
      CSR_TVAL:   v = exp_tval;
      default: begin
        for (int n = 0; n < NUM_SAVE; n++) begin
          if (addr == CSR_SAVE_BASE + csr_addr_t'(n)) begin
            v = exp_save[n];
          end
        end
      end
    endcase
    return v;
  endfunction

  task automatic reset_model();
    exp_crmd    = 32'h8;
    exp_prmd    = 32'h0;
    exp_era     = 32'h0;
    exp_badv    = 32'h0;
    exp_eentry  = 32'h0;
    exp_tid     = 32'h0;
    exp_tcfg    = 32'h0;
    exp_tval    = 32'h0;
    exp_rdata   = 32'h0;
    exp_swi     = 2'b0;
    exp_hwi     = 8'h0;
    exp_ecode   = 6'h0;
    exp_esub    = 9'h0;
    exp_ten     = 1'b0;
    exp_pending = 1'b0;
    exp_counter = 64'd0;
    for (int n = 0; n < NUM_SAVE; n++) begin
      exp_save[n] = 32'h0;
    end
  endtask

  // advance the model by one rising edge using the inputs now driven
  task automatic update_model();
    logic  wen;
    logic  clear;
    word_t wdata;
    word_t cur_crmd;
    word_t cur_prmd;
    wen      = csr_we_i && !stall_i;
    wdata    = (model_read(csr_w_addr_i) & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);
    cur_crmd = exp_crmd;
    cur_prmd = exp_prmd;
    if (!stall_i) begin
      case (rdcnt_i)
        RDCNT_ID:    exp_rdata = exp_tid;
        RDCNT_VLOW:  exp_rdata = exp_counter[31:0];
        RDCNT_VHIGH: exp_rdata = exp_counter[63:32];
        default:     exp_rdata = model_read(csr_r_addr_i);
      endcase
    end
    if (|excp_i) begin
      // pplv/pie sit at the same bits as plv/ie
      exp_prmd[2:0] = cur_crmd[2:0];
      exp_crmd[2:0] = 3'b000;
      exp_era       = pc_i;
      if (excp_i.intr) begin
        exp_ecode = ECODE_INT;
        exp_esub  = 9'd0;
      end else if (excp_i.adef) begin
        exp_ecode = ECODE_ADE;
        exp_esub  = 9'd0;
      end else if (excp_i.adem) begin
        exp_ecode = ECODE_ADE;
        exp_esub  = 9'd1;
      end else begin
        exp_esub  = 9'd0;
        if (excp_i.ale) exp_ecode = ECODE_ALE;
        else if (excp_i.sys) exp_ecode = ECODE_SYS;
        else if (excp_i.brk) exp_ecode = ECODE_BRK;
        else if (excp_i.ine) exp_ecode = ECODE_INE;
        else exp_ecode = ECODE_IPE;
      end
      if (excp_i.adef) exp_badv = pc_i;
      else if (excp_i.adem || excp_i.ale) exp_badv = vaddr_i;
    end else if (ertn_i) begin
      exp_crmd[2:0] = cur_prmd[2:0];
    end
    exp_hwi = int_i;
    if (wen) begin
      if (csr_w_addr_i == CSR_CRMD) exp_crmd = wdata & 32'h1ff;
      if (csr_w_addr_i == CSR_PRMD) exp_prmd = wdata & 32'h7;
      if (csr_w_addr_i == CSR_ESTAT) exp_swi = wdata[1:0];
      if (csr_w_addr_i == CSR_ERA) exp_era = wdata;
      if (csr_w_addr_i == CSR_BADV) exp_badv = wdata;
      if (csr_w_addr_i == CSR_EENTRY) exp_eentry = wdata & 32'hffff_ffc0;
      if (csr_w_addr_i == CSR_TID) exp_tid = wdata;
      for (int n = 0; n < NUM_SAVE; n++) begin
        if (csr_w_addr_i == CSR_SAVE_BASE + csr_addr_t'(n)) exp_save[n] = wdata;
      end
    end
    // timer, clear wins over expiry
    clear = wen && (csr_w_addr_i == CSR_TICLR) && wdata[0];
    if (wen && (csr_w_addr_i == CSR_TCFG)) begin
      exp_tcfg = wdata;
      exp_tval = wdata & 32'hffff_fffc;
      exp_ten  = wdata[0];
    end else if (exp_ten) begin
      if (exp_tval == 32'd0) begin
        exp_pending = 1'b1;
        exp_ten     = exp_tcfg[1];
        exp_tval    = exp_tcfg[1] ? (exp_tcfg & 32'hffff_fffc) : 32'hffff_ffff;
      end else begin
        exp_tval = exp_tval - 32'd1;
      end
    end
    if (clear) exp_pending = 1'b0;
    exp_counter = exp_counter + 64'd1;
  endtask

  task automatic compare_outputs();
    logic irq;
    irq = exp_crmd[2] && ((|exp_swi) || (|exp_hwi) || exp_pending);
    check_value("csr_r_data_o", csr_r_data_o, exp_rdata);
    check_value("crmd_o", crmd_o, exp_crmd);
    check_value("eentry_o", eentry_o, exp_eentry);
    check_value("irq_pending_o", {31'd0, irq_pending_o}, {31'd0, irq});
  endtask

  task automatic drive_idle();
    stall_i      = 1'b0;
    csr_r_addr_i = CSR_CRMD;
    rdcnt_i      = RDCNT_CSR;
    csr_we_i     = 1'b0;
    csr_w_addr_i = CSR_CRMD;
    csr_w_mask_i = 32'h0;
    csr_w_data_i = 32'h0;
    excp_i       = '0;
    ertn_i       = 1'b0;
    int_i        = 8'h0;
    pc_i         = 32'h0;
    vaddr_i      = 32'h0;
  endtask

  task automatic run_cycle();
    update_model();
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic write_csr(input csr_addr_t addr, input word_t mask, input word_t data);
    drive_idle();
    csr_we_i     = 1'b1;
    csr_w_addr_i = addr;
    csr_w_mask_i = mask;
    csr_w_data_i = data;
    run_cycle();
  endtask

  task automatic drive_random(input int phase);
    word_t r;
    word_t s;
    drive_idle();
    r = rand_word();
    s = rand_word();
    csr_r_addr_i = pick_addr(r[3:0]);
    if (r[5:4] == 2'b00) rdcnt_i = rdcnt_e'(r[7:6]);
    stall_i      = (r[9:8] == 2'b00);
    csr_w_addr_i = pick_addr(r[13:10]);
    csr_w_mask_i = rand_word();
    csr_w_data_i = rand_word();
    pc_i         = rand_word();
    vaddr_i      = rand_word();
    case (phase)
      1: csr_we_i = (r[15:14] != 2'b00);
      2: begin
        csr_we_i = (r[15:14] == 2'b00);
        if (r[16]) excp_i = s[7:0];
        else ertn_i = (r[18:17] == 2'b00);
      end
      default: begin
        csr_we_i = r[15];
        stall_i  = (r[9:7] == 3'b000);
        if (r[19:16] == 4'h0) int_i = s[7:0];
        if (r[20]) csr_r_addr_i = r[21] ? CSR_TVAL : CSR_ESTAT;
        // short periods so expiries happen often
        if (csr_w_addr_i == CSR_TCFG) begin
          csr_w_mask_i = 32'hffff_ffff;
          csr_w_data_i = (s & 32'h3e) | 32'h1;
        end
      end
    endcase
  endtask

  task automatic wait_timer_expiry();
    int waited;
    waited = 0;
    while (csr_r_data_o[ESTAT_TI] == 1'b0) begin
      if (waited == TIMEOUT) begin
        $display("timer interrupt bit not seen in ESTAT within %0d cycles", TIMEOUT);
        stop_on_failure();
      end
      drive_idle();
      csr_r_addr_i = CSR_ESTAT;
      run_cycle();
      waited++;
    end
  endtask

  initial begin
    seed  = 68;
    rst_n = 1'b0;
    drive_idle();
    reset_model();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_outputs();

    // crmd after reset, then the counter halves
    drive_idle();
    run_cycle();
    check_value("csr_r_data_o", csr_r_data_o, 32'h0000_0008);
    drive_idle();
    rdcnt_i = RDCNT_VLOW;
    run_cycle();
    drive_idle();
    rdcnt_i = RDCNT_VHIGH;
    run_cycle();
    check_value("csr_r_data_o", csr_r_data_o, 32'h0);

    repeat (400) begin
      drive_random(1);
      run_cycle();
    end
    repeat (400) begin
      drive_random(2);
      run_cycle();
    end

    // one-shot then periodic with interrupts enabled
    write_csr(CSR_CRMD, 32'h4, 32'h4);
    for (int mode = 0; mode < 2; mode++) begin
      write_csr(CSR_TICLR, 32'hffff_ffff, 32'h1);
      write_csr(CSR_TCFG, 32'hffff_ffff, (32'd6 << 2) | (mode == 1 ? 32'h2 : 32'h0) | 32'h1);
      wait_timer_expiry();
    end
    repeat (600) begin
      drive_random(3);
      run_cycle();
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
rtl/csr_pkg.sv
rtl/csr_write_port.sv
rtl/csr_exception_unit.sv
rtl/csr_timer.sv
rtl/csr_scratch_regs.sv
rtl/csr_read_mux.sv
rtl/csr_file.sv
verif/csr_tb.sv

/* run.sh */
#!/bin/sh
# build and run the CSR file testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module csr_tb -o csr_sim

./obj_dir/csr_sim
